//--- pipeline_core.f
+incdir+testbench
src/core_pkg.sv
src/isa_pkg.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/pipeline_core.sv
testbench/pipeline_core_tb.sv

//--- testbench/core_tests.svh
// Instruction word from its fields
function automatic logic [31:0] encode(input logic imm_flag, input logic [1:0] kind,
                                       input logic [2:0] op, input logic [2:0] rd,
                                       input logic [2:0] rs2, input logic [15:0] imm);
  logic [31:0] word;
  word = '0;
  word[imm_flag_bit] = imm_flag;
  word[type_msb:type_lsb] = kind;
  word[op_msb:op_lsb] = op;
  word[rd_msb:rd_lsb] = rd;
  word[rs2_msb:rs2_lsb] = rs2;
  word[imm_msb:imm_lsb] = imm;
  return word;
endfunction

// Register model, one instruction at a time in program order
task automatic apply_model(input logic [31:0] word);
  logic [2:0]  op;
  logic [2:0]  rd;
  logic [31:0] operand_2;
  op = word[op_msb:op_lsb];
  rd = word[rd_msb:rd_lsb];
  if (!word[imm_flag_bit])
    operand_2 = model_regs[word[rs2_msb:rs2_lsb]];
  else if (op == op_move_upper)
    operand_2 = {word[15:0], 16'h0000};
  else
    operand_2 = {16'h0000, word[15:0]};
  if (word[type_msb:type_lsb] == type_alu) begin  // Memory and audio do nothing
    case (op)
      op_add:        model_regs[rd] = model_regs[rd] + operand_2;
      op_inc:        model_regs[rd] = model_regs[rd] + 32'd1;
      op_move_lower: model_regs[rd][15:0] = operand_2[15:0];
      op_move_upper: model_regs[rd][31:16] = operand_2[31:16];
      op_move:       model_regs[rd] = operand_2;
      default:       model_regs[rd] = '0;
    endcase
  end
endtask

task automatic load_instr(input logic [31:0] word);
  imem[prog_len] = word;
  apply_model(word);
  prog_len++;
endtask

task automatic load_alu(input logic imm_flag, input logic [2:0] op, input logic [2:0] rd,
                        input logic [2:0] rs2, input logic [15:0] imm);
  load_instr(encode(imm_flag, type_alu, op, rd, rs2, imm));
endtask

// Core held in reset while the program is loaded
task automatic start_test;
  int a;
  @(posedge clock);
  reset <= 1'b1;
  @(negedge clock);
  for (a = 0; a < 256; a++) begin
    imem[a] = '0;
  end
  for (a = 0; a < reg_count; a++) begin
    model_regs[a] = '0;
  end
  prog_len = 0;
  stall_count = 0;
endtask

task automatic release_reset;
  repeat (2) @(posedge clock);
  reset <= 1'b0;
endtask

task automatic wait_for_end;
  int cycles;
  cycles = 0;
  while (pc < prog_len + 4 && cycles < 4 * prog_len + 16) begin
    @(negedge clock);
    cycles++;
  end
  if (pc < prog_len + 4) begin
    error_count++;
    $display("Program of %0d words did not run to its end, pc stopped at %0d", prog_len, pc);
  end
endtask

task automatic run_program;
  release_reset();
  wait_for_end();
endtask

task automatic check_registers;
  int r;
  for (r = 0; r < reg_count; r++) begin
    @(posedge clock);
    view_select <= r[2:0];
    @(negedge clock);
    check_value($sformatf("view_value[r%0d]", r), view_value, model_regs[r]);
  end
endtask

task automatic test_reset_state;
  start_test();
  release_reset();
  @(negedge clock);
  check_value("pc", pc, 32'd0);
  check_value("stall", stall, 32'd0);
  wait_for_end();
  check_registers();
endtask

task automatic test_moves;
  start_test();
  load_alu(1'b1, op_move_lower, 3'd1, 3'd0, random_half());
  load_alu(1'b1, op_move_upper, 3'd1, 3'd0, random_half());  // Lower half kept
  load_alu(1'b0, op_move, 3'd4, 3'd1, 16'h0000);  // Snapshot of both halves
  load_alu(1'b1, op_move_lower, 3'd1, 3'd0, random_half());  // Upper half kept
  load_alu(1'b0, op_move, 3'd2, 3'd1, random_half());
  load_alu(1'b0, op_move_upper, 3'd3, 3'd1, random_half());
  run_program();
  check_registers();
endtask

task automatic test_alu;
  start_test();
  load_alu(1'b1, op_move_lower, 3'd1, 3'd0, random_half());
  load_alu(1'b1, op_move_upper, 3'd1, 3'd0, random_half());
  load_alu(1'b1, op_move_lower, 3'd2, 3'd0, random_half());
  load_alu(1'b0, op_add, 3'd1, 3'd2, 16'h0000);  // Register operands
  load_alu(1'b1, op_add, 3'd3, 3'd0, random_half());
  load_alu(1'b0, op_inc, 3'd2, 3'd5, 16'h0000);
  load_alu(1'b1, op_move_lower, 3'd4, 3'd0, random_half());
  load_alu(1'b0, 3'b000, 3'd4, 3'd2, 16'h0000);  // Unlisted op writes zero
  load_alu(1'b0, op_move, 3'd5, 3'd1, 16'h0000);
  load_alu(1'b1, 3'b100, 3'd5, 3'd0, random_half());
  run_program();
  check_registers();
endtask

task automatic test_hazard;
  start_test();
  load_alu(1'b1, op_move_lower, 3'd5, 3'd0, random_half());
  load_alu(1'b0, op_add, 3'd5, 3'd5, 16'h0000);  // Needs r5 right away
  load_alu(1'b0, op_inc, 3'd5, 3'd0, 16'h0000);
  load_alu(1'b1, op_add, 3'd6, 3'd0, random_half());
  load_alu(1'b0, op_move, 3'd7, 3'd6, 16'h0000);  // Dependent through rs2
  run_program();
  check_registers();
  check_value("stall seen", stall_count != 0, 32'd1);
endtask

task automatic test_no_false_stall;
  start_test();
  load_alu(1'b1, op_move_lower, 3'd6, 3'd0, random_half());
  load_alu(1'b0, op_inc, 3'd7, 3'd6, 16'h0000);  // INC ignores rs2
  run_program();
  check_registers();
  check_value("stall cycles", stall_count, 32'd0);
endtask

task automatic test_nop_types;
  start_test();
  load_alu(1'b1, op_move_lower, 3'd1, 3'd0, random_half());
  load_alu(1'b1, op_move_upper, 3'd2, 3'd0, random_half());
  load_alu(1'b1, op_add, 3'd3, 3'd0, random_half());
  load_instr(encode(1'b1, type_memory, op_add, 3'd1, 3'd2, random_half()));
  load_instr(encode(1'b0, type_audio, op_move, 3'd2, 3'd1, random_half()));
  load_instr(encode(1'b1, type_nop, op_move_lower, 3'd3, 3'd0, random_half()));
  load_instr(encode(1'b0, type_nop, op_inc, 3'd1, 3'd3, random_half()));
  run_program();
  check_registers();
endtask

task automatic test_random;
  alu_op_e     ops [5] = '{op_add, op_inc, op_move_lower, op_move_upper, op_move};
  logic [31:0] pick;
  int          i;
  start_test();
  for (i = 0; i < 12; i++) begin
    pick = next_random();
    load_alu(pick[0], ops[pick[15:8] % 5], pick[3:1], pick[6:4], pick[31:16]);
  end
  run_program();
  check_registers();
endtask

//--- testbench/pipeline_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core_tb import core_pkg::*, isa_pkg::*; ();

  localparam int clock_period   = 8;
  localparam int program_words  = 42;  // Sum over all directed tests
  localparam int test_count     = 7;
  localparam int test_overhead  = 24;  // Reset, drain and register readout
  localparam int timeout_ns     = (program_words + test_count * test_overhead)
                                  * clock_period * 3;

  logic                     clock;
  logic                     reset;
  logic [instr_width-1:0]   instr;
  logic [pc_width-1:0]      pc;
  logic                     stall;
  logic [reg_sel_width-1:0] view_select;
  logic [data_width-1:0]    view_value;

  logic [instr_width-1:0]   imem [256];  // Indexed by pc
  logic [data_width-1:0]    model_regs [reg_count];
  int                       prog_len;
  int                       stall_count;
  int                       check_count;
  int                       error_count;
  logic [31:0]              rand_state;

  assign instr = imem[pc];  // Combinational instruction memory

  pipeline_core UUT (
    .clock       (clock),
    .reset       (reset),
    .instr       (instr),
    .pc          (pc),
    .stall       (stall),
    .view_select (view_select),
    .view_value  (view_value)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // Stall cycles seen since the last reset
  always @(negedge clock) begin
    if (!reset && stall)
      stall_count++;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  function automatic logic [31:0] next_random();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  function automatic logic [15:0] random_half();
    logic [31:0] value;
    value = next_random();
    return value[15:0];
  endfunction

  `include "core_tests.svh"

  initial begin
    int a;
    reset       = 1'b1;
    view_select = '0;
    rand_state  = 32'd70;
    check_count = 0;
    error_count = 0;
    stall_count = 0;
    prog_len    = 0;
    for (a = 0; a < 256; a++) begin
      imem[a] = '0;
    end
    test_reset_state();
    test_moves();
    test_alu();
    test_hazard();
    test_no_false_stall();
    test_nop_types();
    test_random();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout_ns);
    $display("Timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core import core_pkg::*, isa_pkg::*; (
  input  wire                     clock,
  input  wire                     reset,
  input  wire [instr_width-1:0]   instr,
  output logic [pc_width-1:0]     pc,
  output logic                    stall,
  input  wire [reg_sel_width-1:0] view_select,
  output logic [data_width-1:0]   view_value
);

  logic [instr_width-1:0]   fetched_instr;

  // Register file read side
  logic [reg_sel_width-1:0] read_select_1;
  logic [reg_sel_width-1:0] read_select_2;
  logic [data_width-1:0]    read_value_1;
  logic [data_width-1:0]    read_value_2;

  // Decode/execute register
  alu_op_e                  ex_op;
  logic [data_width-1:0]    ex_operand_1;
  logic [data_width-1:0]    ex_operand_2;
  result_sel_e              ex_result_sel;
  logic [reg_sel_width-1:0] ex_dest;
  half_we_t                 ex_write_enable;

  // Writeback straight from execute
  half_we_t                 write_enable;
  logic [reg_sel_width-1:0] write_select;
  logic [data_width-1:0]    write_data;

  fetch_stage fetch (
    .clock         (clock),
    .reset         (reset),
    .stall         (stall),
    .instr         (instr),
    .pc            (pc),
    .fetched_instr (fetched_instr)
  );

  decode_stage decode (
    .clock           (clock),
    .reset           (reset),
    .fetched_instr   (fetched_instr),
    .read_select_1   (read_select_1),
    .read_select_2   (read_select_2),
    .read_value_1    (read_value_1),
    .read_value_2    (read_value_2),
    .stall           (stall),
    .ex_op           (ex_op),
    .ex_operand_1    (ex_operand_1),
    .ex_operand_2    (ex_operand_2),
    .ex_result_sel   (ex_result_sel),
    .ex_dest         (ex_dest),
    .ex_write_enable (ex_write_enable)
  );

  execute_stage execute (
    .ex_op           (ex_op),
    .ex_operand_1    (ex_operand_1),
    .ex_operand_2    (ex_operand_2),
    .ex_result_sel   (ex_result_sel),
    .ex_dest         (ex_dest),
    .ex_write_enable (ex_write_enable),
    .write_enable    (write_enable),
    .write_select    (write_select),
    .write_data      (write_data)
  );

  register_file regs (
    .clock         (clock),
    .reset         (reset),
    .read_select_1 (read_select_1),
    .read_select_2 (read_select_2),
    .read_value_1  (read_value_1),
    .read_value_2  (read_value_2),
    .write_enable  (write_enable),
    .write_select  (write_select),
    .write_data    (write_data),
    .view_select   (view_select),
    .view_value    (view_value)
  );

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_pkg::*, isa_pkg::*; (
  input  wire alu_op_e             ex_op,
  input  wire [data_width-1:0]     ex_operand_1,
  input  wire [data_width-1:0]     ex_operand_2,
  input  wire result_sel_e         ex_result_sel,
  input  wire [reg_sel_width-1:0]  ex_dest,
  input  wire half_we_t            ex_write_enable,
  output half_we_t                 write_enable,
  output logic [reg_sel_width-1:0] write_select,
  output logic [data_width-1:0]    write_data
);

  logic [data_width-1:0] alu_result;

  // ALU, unknown ops give zero
  always_comb begin
    case (ex_op)
      op_add:  alu_result = ex_operand_1 + ex_operand_2;
      op_inc:  alu_result = ex_operand_1 + 1'b1;
      default: alu_result = '0;
    endcase
  end

  // Result select
  always_comb begin
    case (ex_result_sel)
      sel_alu:  write_data = alu_result;
      sel_move: write_data = ex_operand_2;  // Moves pass operand 2
      default:  write_data = '0;
    endcase
  end

  // Register write straight from the pipeline register
  assign write_enable = ex_write_enable;
  assign write_select = ex_dest;

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import core_pkg::*, isa_pkg::*; (
  input  wire                     clock,
  input  wire                     reset,
  input  wire [instr_width-1:0]   fetched_instr,
  output logic [reg_sel_width-1:0] read_select_1,
  output logic [reg_sel_width-1:0] read_select_2,
  input  wire [data_width-1:0]    read_value_1,
  input  wire [data_width-1:0]    read_value_2,
  output logic                    stall,
  output alu_op_e                 ex_op,
  output logic [data_width-1:0]   ex_operand_1,
  output logic [data_width-1:0]   ex_operand_2,
  output result_sel_e             ex_result_sel,
  output logic [reg_sel_width-1:0] ex_dest,
  output half_we_t                ex_write_enable
);

  // Instruction fields
  logic                     imm_flag;
  instr_type_e              instr_type;
  alu_op_e                  op;
  logic [reg_sel_width-1:0] rs1;
  logic [reg_sel_width-1:0] rs2;
  logic [imm_width-1:0]     imm;

  logic                     is_alu;
  logic                     is_move;
  logic                     reads_rs2;
  logic [data_width-1:0]    operand_2;
  half_we_t                 write_enable;
  result_sel_e              result_sel;

  assign imm_flag   = fetched_instr[imm_flag_bit];
  assign instr_type = instr_type_e'(fetched_instr[type_msb:type_lsb]);
  assign op         = alu_op_e'(fetched_instr[op_msb:op_lsb]);
  assign rs1        = fetched_instr[rd_msb:rd_lsb];
  assign rs2        = fetched_instr[rs2_msb:rs2_lsb];
  assign imm        = fetched_instr[imm_msb:imm_lsb];

  assign read_select_1 = rs1;
  assign read_select_2 = rs2;

  // Memory and audio types fall through as nops
  assign is_alu  = (instr_type == type_alu);
  assign is_move = is_alu && (op == op_move_lower || op == op_move_upper || op == op_move);

  // INC and immediate forms never look at rs2
  assign reads_rs2 = is_alu && !imm_flag && (op != op_inc);

  // Producer still in execute
  always_comb begin
    stall = 1'b0;
    if (is_alu && ex_write_enable != 2'b00) begin
      if (ex_dest == rs1)
        stall = 1'b1;
      else if (reads_rs2 && ex_dest == rs2)
        stall = 1'b1;
    end
  end

  // Second operand from rs2 or the immediate
  always_comb begin
    if (!imm_flag)
      operand_2 = read_value_2;
    else if (op == op_move_upper)
      operand_2 = {imm, {half_width{1'b0}}};
    else
      operand_2 = {{half_width{1'b0}}, imm};
  end

  always_comb begin
    write_enable = 2'b00;
    result_sel   = sel_none;
    if (is_alu) begin
      result_sel = is_move ? sel_move : sel_alu;
      case (op)
        op_move_lower: write_enable = 2'b01;
        op_move_upper: write_enable = 2'b10;
        default:       write_enable = 2'b11;
      endcase
    end
  end

  // Control half of the decode/execute register, bubble on stall
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ex_write_enable <= 2'b00;
      ex_result_sel   <= sel_none;
    end else if (stall) begin
      ex_write_enable <= 2'b00;
      ex_result_sel   <= sel_none;
    end else begin
      ex_write_enable <= write_enable;
      ex_result_sel   <= result_sel;
    end
  end

  // Payload, only meaningful with a write enable
  always_ff @(posedge clock) begin
    ex_op        <= op;
    ex_operand_1 <= read_value_1;
    ex_operand_2 <= operand_2;
    ex_dest      <= rs1;
  end

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import core_pkg::*; (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   stall,
  input  wire [data_width-1:0]  instr,
  output logic [pc_width-1:0]   pc,
  output logic [data_width-1:0] fetched_instr
);

  // Program counter, held while decode is stalled
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pc + 1'b1;
    end
  end

  // Instruction register, all zero is a nop
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      fetched_instr <= '0;
    end else if (!stall) begin
      fetched_instr <= instr;  // Memory answers for the current pc
    end
  end

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import core_pkg::*; (
  input  wire                     clock,
  input  wire                     reset,
  input  wire [reg_sel_width-1:0] read_select_1,
  input  wire [reg_sel_width-1:0] read_select_2,
  output logic [data_width-1:0]   read_value_1,
  output logic [data_width-1:0]   read_value_2,
  input  wire half_we_t           write_enable,
  input  wire [reg_sel_width-1:0] write_select,
  input  wire [data_width-1:0]    write_data,
  input  wire [reg_sel_width-1:0] view_select,
  output logic [data_width-1:0]   view_value
);

  logic [data_width-1:0] regs [reg_count];

  // Stored value with this cycle's write merged in per half
  function automatic logic [data_width-1:0] read_merged(
    input logic [reg_sel_width-1:0] sel
  );
    logic [data_width-1:0] value;
    value = regs[sel];
    if (sel == write_select) begin
      if (write_enable[0])
        value[half_width-1:0] = write_data[half_width-1:0];
      if (write_enable[1])
        value[data_width-1:half_width] = write_data[data_width-1:half_width];
    end
    return value;
  endfunction

  always_comb begin
    read_value_1 = read_merged(read_select_1);
  end

  always_comb begin
    read_value_2 = read_merged(read_select_2);
  end

  always_comb begin
    view_value = read_merged(view_select);  // Debug view
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (write_enable[0])
        regs[write_select][half_width-1:0] <= write_data[half_width-1:0];
      if (write_enable[1])
        regs[write_select][data_width-1:half_width] <= write_data[data_width-1:half_width];
    end
  end

endmodule

`default_nettype wire

//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // Instruction word layout
  localparam int instr_width  = 32;
  localparam int imm_flag_bit = 31;

  localparam int type_msb = 30;
  localparam int type_lsb = 29;
  localparam int op_msb   = 28;
  localparam int op_lsb   = 26;

  // rd doubles as the first source register
  localparam int rd_msb  = 21;
  localparam int rd_lsb  = 19;
  localparam int rs2_msb = 18;
  localparam int rs2_lsb = 16;
  localparam int imm_msb = 15;
  localparam int imm_lsb = 0;

  // Field widths
  localparam int type_width = type_msb - type_lsb + 1;
  localparam int op_width   = op_msb - op_lsb + 1;
  localparam int imm_width  = imm_msb - imm_lsb + 1;

  typedef enum logic [type_width-1:0] {
    type_nop    = 2'b00,
    type_alu    = 2'b01,
    type_memory = 2'b10,  // Decoded as nop in this core
    type_audio  = 2'b11   // Decoded as nop in this core
  } instr_type_e;

  // Unlisted codes are ALU ops that produce zero
  typedef enum logic [op_width-1:0] {
    op_add        = 3'b001,
    op_inc        = 3'b011,
    op_move_lower = 3'b101,
    op_move_upper = 3'b110,
    op_move       = 3'b111
  } alu_op_e;

endpackage

`default_nettype wire

//--- src/core_pkg.sv
`default_nettype none

package core_pkg;

  // Datapath sizes
  localparam int data_width    = 32;
  localparam int half_width    = 16;
  localparam int reg_count     = 8;
  localparam int reg_sel_width = 3;
  localparam int pc_width      = 8;

  // Bit 0 writes the lower half, bit 1 the upper half
  typedef logic [1:0] half_we_t;

  // Which value goes to the register file
  typedef enum logic [1:0] {
    sel_none = 2'b00,
    sel_alu  = 2'b01,
    sel_move = 2'b10
  } result_sel_e;

endpackage

`default_nettype wire
